//--- build.f
+incdir+source
+incdir+dv
source/core_types_pkg.sv
source/mem_bus_pkg.sv
source/inst_decode.sv
source/inst_fetch.sv
source/reg_file_bypass.sv
source/execute.sv
source/mem_arbiter.sv
source/unified_mem.sv
source/core_top.sv
dv/core_tb.sv

//--- run.sh
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module core_tb -Mdir obj_dir -o core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1

//--- dv/core_prog.svh
`ifndef CORE_PROG_SVH
`define CORE_PROG_SVH

data_t    prog [$];
reg_idx_t exp_idx [$];
data_t    exp_val [$];
int       exp_tag [$];  // number of the behavior the commit belongs to
data_t    model [32];
data_t    stored_val;

function automatic data_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic void push_commit(reg_idx_t rd, data_t val, int tag);
    if (rd != '0) begin
        model[rd] = val;
        exp_idx.push_back(rd);
        exp_val.push_back(val);
        exp_tag.push_back(tag);
    end
endfunction

function automatic void emit_addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm, int tag);
    prog.push_back({imm, rs1, 3'b000, rd, 7'b0010011});
    push_commit(rd, model[rs1] + sext12(imm), tag);
endfunction

function automatic void emit_alu(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                 reg_idx_t rs1, reg_idx_t rs2, int tag);
    data_t a;
    data_t b;
    data_t res;
    a = model[rs1];
    b = model[rs2];
    case (f3)
        3'b000:  res = f7[5] ? a - b : a + b;
        3'b100:  res = a ^ b;
        3'b110:  res = a | b;
        default: res = a & b;
    endcase
    prog.push_back({f7, rs2, rs1, f3, rd, 7'b0110011});
    push_commit(rd, res, tag);
endfunction

// lui then addi with the upper part rounded for the sign of the low 12 bits
function automatic void load_const(reg_idx_t rd, data_t value);
    data_t hi;
    hi = value + 32'h800;
    prog.push_back({hi[31:12], rd, 7'b0110111});
    push_commit(rd, {hi[31:12], 12'b0}, 2);
    emit_addi(rd, rd, value[11:0], 2);
endfunction

function automatic void store_load(logic [11:0] off, reg_idx_t src, reg_idx_t dst);
    stored_val = model[src];
    prog.push_back({off[11:5], src, 5'd0, 3'b010, off[4:0], 7'b0100011});
    prog.push_back({off, 5'd0, 3'b010, dst, 7'b0000011});
    push_commit(dst, stored_val, 4);
endfunction

// branch by +8 over one addi, which commits only if not taken
function automatic void branch_over(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                    reg_idx_t shadow_rd);
    logic taken;
    taken = (model[rs1] == model[rs2]) != (f3 == 3'b001);
    prog.push_back({7'b0, rs2, rs1, f3, 5'b01000, 7'b1100011});
    prog.push_back({12'd1, 5'd0, 3'b000, shadow_rd, 7'b0010011});
    if (!taken) begin
        push_commit(shadow_rd, 32'd1, 5);
    end
endfunction

function automatic void jal_over(reg_idx_t rd);
    data_t link;
    link = data_t'(prog.size() * 4 + 4);
    prog.push_back({1'b0, 10'd4, 1'b0, 8'd0, rd, 7'b1101111});
    prog.push_back({12'd3, 5'd0, 3'b000, 5'd17, 7'b0010011});  // never runs
    push_commit(rd, link, 5);
endfunction

function automatic void build_program();
    model = '{default: '0};
    load_const(5'd1, $urandom());
    load_const(5'd2, $urandom());
    emit_alu(7'h00, 3'b000, 5'd3, 5'd1, 5'd2, 2);  // add
    emit_alu(7'h20, 3'b000, 5'd4, 5'd3, 5'd1, 2);  // sub
    emit_alu(7'h00, 3'b111, 5'd5, 5'd4, 5'd2, 2);
    emit_alu(7'h00, 3'b110, 5'd6, 5'd5, 5'd1, 2);
    emit_alu(7'h00, 3'b100, 5'd7, 5'd6, 5'd3, 2);
    emit_addi(5'd8, 5'd7, 12'd5, 2);
    emit_addi(5'd8, 5'd8, 12'hffd, 2);
    emit_addi(5'd8, 5'd8, 12'd100, 2);
    load_const(5'd11, $urandom());
    store_load(DATA_OFF, 5'd11, 5'd9);
    emit_alu(7'h00, 3'b000, 5'd10, 5'd9, 5'd2, 4);  // uses the loaded word
    branch_over(3'b000, 5'd1, 5'd1, 5'd12);
    branch_over(3'b001, 5'd1, 5'd1, 5'd13);
    branch_over(3'b001, 5'd13, 5'd0, 5'd14);
    jal_over(5'd15);
    prog.push_back(32'h0010_0073);  // ebreak
    prog.push_back({12'd2, 5'd0, 3'b000, 5'd16, 7'b0010011});
endfunction

`endif

//--- dv/core_tb.sv
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam logic [11:0] DATA_OFF   = 12'h200;
    localparam mem_idx_t    DATA_IDX   = mem_idx_t'(DATA_OFF >> 2);

    logic     clock;
    logic     rst_n;
    logic     run;
    logic     load_req;
    addr_t    load_addr;
    data_t    load_wdata;
    logic     wb_en;
    reg_idx_t wb_idx;
    data_t    wb_data;
    logic     halted;

    int       exp_ptr;
    int       exp_count;
    reg_idx_t head_idx;
    data_t    head_val;
    int       head_tag;
    int       fails [1:6];
    int       commits_by_tag [1:6];
    int       fwd_hits;
    int       tests_failed;
    int       wd_ns;

    `include "core_prog.svh"

    core_top uut (
        .clock(clock), .rst_n(rst_n), .run(run),
        .load_req(load_req), .load_addr(load_addr), .load_wdata(load_wdata),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data), .halted(halted)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic void record_failure(int test, string msg);
        fails[test]++;
        $display("%s", msg);
    endfunction

    function automatic void report_test(int test, string name, bit reached);
        if (!reached) begin
            record_failure(test, $sformatf("test %0d never reached its check", test));
        end
        if (fails[test] == 0) begin
            $display("test %0d %s: pass", test, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", test, name, fails[test]);
            tests_failed++;
        end
    endfunction

    idle_no_commit: assert property (@(negedge clock) disable iff (!rst_n) !run |-> !wb_en)
        else record_failure(1, $sformatf("error %0t wb_en expected 0 got %b", $time, wb_en));
    idle_no_halt: assert property (@(negedge clock) disable iff (!rst_n) !run |-> !halted)
        else record_failure(1, $sformatf("error %0t halted expected 0 got %b", $time, halted));

    commit_expected: assert property (@(negedge clock) disable iff (!rst_n)
        wb_en |-> exp_ptr < exp_count)
        else record_failure(halted ? 6 : 5, $sformatf("commit to x%0d at %0t with nothing left",
                            wb_idx, $time));
    commit_idx: assert property (@(negedge clock) disable iff (!rst_n)
        wb_en && exp_ptr < exp_count |-> wb_idx == head_idx)
        else record_failure(head_tag, $sformatf("error %0t wb_idx expected %0d got %0d",
                            $time, head_idx, wb_idx));
    commit_data: assert property (@(negedge clock) disable iff (!rst_n)
        wb_en && exp_ptr < exp_count |-> wb_data == head_val)
        else record_failure(head_tag, $sformatf("error %0t wb_data expected %h got %h",
                            $time, head_val, wb_data));

    fwd_rs1: assert property (@(negedge clock) disable iff (!rst_n)
        uut.if_valid && wb_en && exp_ptr < exp_count && uut.rs1 == head_idx
        |-> uut.rs1_data == head_val)
        else record_failure(3, $sformatf("error %0t rs1_data expected %h got %h",
                            $time, head_val, uut.rs1_data));
    fwd_rs2: assert property (@(negedge clock) disable iff (!rst_n)
        uut.if_valid && wb_en && exp_ptr < exp_count && uut.rs2 == head_idx
        |-> uut.rs2_data == head_val)
        else record_failure(3, $sformatf("error %0t rs2_data expected %h got %h",
                            $time, head_val, uut.rs2_data));

    halt_is_final: assert property (@(negedge clock) disable iff (!rst_n) halted |-> !wb_en)
        else record_failure(6, $sformatf("error %0t wb_en expected 0 got %b", $time, wb_en));

    always @(negedge clock) begin
        if (rst_n && uut.if_valid && wb_en && (uut.rs1 == wb_idx || uut.rs2 == wb_idx)) begin
            fwd_hits++;
        end
    end

    // step to the next expected commit
    always @(posedge clock) begin
        if (rst_n && wb_en && exp_ptr < exp_count) begin
            commits_by_tag[head_tag] <= commits_by_tag[head_tag] + 1;
            exp_ptr <= exp_ptr + 1;
            if (exp_ptr + 1 < exp_count) begin
                head_idx <= exp_idx[exp_ptr + 1];
                head_val <= exp_val[exp_ptr + 1];
                head_tag <= exp_tag[exp_ptr + 1];
            end
        end
    end

    initial begin
        int t;
        void'($urandom(32'h1a54));
        clock      = 1'b0;
        rst_n      = 1'b0;
        run        = 1'b0;
        load_req   = 1'b0;
        load_addr  = '0;
        load_wdata = '0;
        exp_ptr      = 0;
        fwd_hits     = 0;
        tests_failed = 0;
        for (t = 1; t <= 6; t++) begin
            fails[t]          = 0;
            commits_by_tag[t] = 0;
        end

        build_program();
        exp_count = exp_idx.size();
        head_idx  = exp_idx[0];
        head_val  = exp_val[0];
        head_tag  = exp_tag[0];
        wd_ns     = prog.size() * 40 * CLK_PERIOD;

        fork
            begin
                #(wd_ns);
                $display("timeout after %0d ns, halted never rose", wd_ns);
                $display("STATUS: FAIL");
                $finish;
            end
        join_none

        repeat (10) @(negedge clock);
        rst_n = 1'b1;
        foreach (prog[i]) begin
            @(negedge clock);
            load_req   = 1'b1;
            load_addr  = i * 4;
            load_wdata = prog[i];
        end
        @(negedge clock);
        load_req = 1'b0;
        repeat (2) @(negedge clock);
        report_test(1, "idle and program load", 1'b1);

        run = 1'b1;
        wait (halted);
        repeat (4) @(negedge clock);  // room for a stray commit to show up

        stored_word: assert (uut.u_mem.mem[DATA_IDX] == stored_val)
            else record_failure(4, $sformatf("error %0t u_mem.mem expected %h got %h",
                                $time, stored_val, uut.u_mem.mem[DATA_IDX]));
        queue_drained: assert (exp_ptr == exp_count)
            else record_failure(6, $sformatf("%0d expected commits missing at halt",
                                exp_count - exp_ptr));
        report_test(2, "alu and immediate commits", commits_by_tag[2] > 0);
        report_test(3, "forwarding from memory stage", fwd_hits > 0);
        report_test(4, "store then load", commits_by_tag[4] == 2);
        report_test(5, "branches and jal", commits_by_tag[5] == 2);
        report_test(6, "ebreak halt", halted);

        $display("tests passed %0d failed %0d", 6 - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- source/core_top.sv
module core_top (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic                     load_req,
    input  core_types_pkg::addr_t    load_addr,
    input  core_types_pkg::data_t    load_wdata,
    output logic                     wb_en,
    output core_types_pkg::reg_idx_t wb_idx,
    output core_types_pkg::data_t    wb_data,
    output logic                     halted
);
    import core_types_pkg::*;
    import mem_bus_pkg::*;

    logic       fetch_req, fetch_gnt, if_valid, redirect, halt_seen;
    addr_t      fetch_addr, if_pc, redirect_pc;
    data_t      inst;
    reg_idx_t   rs1, rs2, m_rd;
    data_t      rs1_data, rs2_data, m_result;
    logic       data_req, data_we, m_valid, m_is_load;
    addr_t      data_addr;
    data_t      data_wdata;
    byte_en_t   data_be, mem_be;
    logic       mem_en, mem_we;
    mem_idx_t   mem_idx;
    data_t      mem_wdata, mem_rdata;
    requester_e last_owner;

    inst_fetch u_fetch (
        .clock(clock), .rst_n(rst_n), .run(run), .halted(halted),
        .fetch_gnt(fetch_gnt), .redirect(redirect), .redirect_pc(redirect_pc),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .if_valid(if_valid), .if_pc(if_pc)
    );

    // only a fetch grant returns an instruction word
    assign inst = (last_owner == REQ_FETCH) ? mem_rdata : '0;

    execute u_execute (
        .clock(clock), .rst_n(rst_n),
        .if_valid(if_valid), .if_pc(if_pc), .inst(inst),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .rs1(rs1), .rs2(rs2),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_be(data_be),
        .m_valid(m_valid), .m_rd(m_rd), .m_result(m_result), .m_is_load(m_is_load),
        .halt_seen(halt_seen)
    );

    reg_file_bypass u_regs (
        .clock(clock), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wb_en), .wr_idx(wb_idx), .wr_data(wb_data)
    );

    mem_arbiter u_arbiter (
        .clock(clock), .rst_n(rst_n),
        .load_req(load_req), .load_addr(load_addr), .load_wdata(load_wdata),
        .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_be(data_be),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_gnt(fetch_gnt), .data_gnt(),
        .mem_en(mem_en), .mem_we(mem_we), .mem_idx(mem_idx),
        .mem_wdata(mem_wdata), .mem_be(mem_be), .last_owner(last_owner)
    );

    unified_mem u_mem (
        .clock(clock), .mem_en(mem_en), .mem_we(mem_we), .mem_idx(mem_idx),
        .mem_wdata(mem_wdata), .mem_be(mem_be), .mem_rdata(mem_rdata)
    );

    // commit from the memory stage
    assign wb_en   = m_valid;
    assign wb_idx  = m_rd;
    assign wb_data = (m_is_load && last_owner == REQ_DATA) ? mem_rdata : m_result;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (halt_seen) begin
            halted <= 1'b1;  // sticky until reset
        end
    end

endmodule

//--- source/unified_mem.sv
`include "core_settings.svh"

module unified_mem (
    input  logic                  clock,
    input  logic                  mem_en,
    input  logic                  mem_we,
    input  mem_bus_pkg::mem_idx_t mem_idx,
    input  core_types_pkg::data_t mem_wdata,
    input  mem_bus_pkg::byte_en_t mem_be,
    output core_types_pkg::data_t mem_rdata
);
    import core_types_pkg::*;

    data_t mem [`MEM_WORDS];

    always_ff @(posedge clock) begin
        if (mem_en) begin
            if (mem_we) begin
                for (int b = 0; b < `DATA_WIDTH/8; b++) begin
                    if (mem_be[b]) begin
                        mem[mem_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
                    end
                end
            end else begin
                mem_rdata <= mem[mem_idx];
            end
        end
    end

endmodule

//--- source/mem_arbiter.sv
module mem_arbiter (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    load_req,
    input  core_types_pkg::addr_t   load_addr,
    input  core_types_pkg::data_t   load_wdata,
    input  logic                    data_req, data_we,
    input  core_types_pkg::addr_t   data_addr,
    input  core_types_pkg::data_t   data_wdata,
    input  mem_bus_pkg::byte_en_t   data_be,
    input  logic                    fetch_req,
    input  core_types_pkg::addr_t   fetch_addr,
    output logic                    fetch_gnt, data_gnt,
    output logic                    mem_en, mem_we,
    output mem_bus_pkg::mem_idx_t   mem_idx,
    output core_types_pkg::data_t   mem_wdata,
    output mem_bus_pkg::byte_en_t   mem_be,
    output mem_bus_pkg::requester_e last_owner
);
    import core_types_pkg::*;
    import mem_bus_pkg::*;

    requester_e owner;
    addr_t      sel_addr;

    always_comb begin
        owner     = REQ_NONE;
        sel_addr  = fetch_addr;
        mem_we    = 1'b0;
        mem_wdata = data_wdata;
        mem_be    = '1;
        if (load_req) begin
            owner     = REQ_LOADER;
            sel_addr  = load_addr;
            mem_we    = 1'b1;  // loader only writes
            mem_wdata = load_wdata;
        end else if (data_req) begin
            owner    = REQ_DATA;
            sel_addr = data_addr;
            mem_we   = data_we;
            mem_be   = data_be;
        end else if (fetch_req) begin
            owner = REQ_FETCH;
        end
    end

    assign mem_en    = (owner != REQ_NONE);
    assign mem_idx   = sel_addr[$bits(mem_idx_t)+1:2];  // byte to word
    assign fetch_gnt = (owner == REQ_FETCH);
    assign data_gnt  = (owner == REQ_DATA);

    // tags the read data returning next cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            last_owner <= REQ_NONE;
        end else begin
            last_owner <= owner;
        end
    end

endmodule

//--- source/execute.sv
module execute (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     if_valid,
    input  core_types_pkg::addr_t    if_pc,
    input  core_types_pkg::data_t    inst,
    input  core_types_pkg::data_t    rs1_data, rs2_data,
    output core_types_pkg::reg_idx_t rs1, rs2,
    output logic                     redirect,
    output core_types_pkg::addr_t    redirect_pc,
    output logic                     data_req, data_we,
    output core_types_pkg::addr_t    data_addr,
    output core_types_pkg::data_t    data_wdata,
    output mem_bus_pkg::byte_en_t    data_be,
    output logic                     m_valid,
    output core_types_pkg::reg_idx_t m_rd,
    output core_types_pkg::data_t    m_result,
    output logic                     m_is_load,
    output logic                     halt_seen
);
    import core_types_pkg::*;

    reg_idx_t rd;
    data_t    imm;
    data_t    op_b;
    data_t    alu_out;
    alu_op_e  alu_op;
    br_kind_e br_kind;
    logic     use_imm, reg_write, is_load, is_store, is_halt;
    logic     taken;

    inst_decode u_decode (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .use_imm(use_imm), .reg_write(reg_write), .is_load(is_load),
        .is_store(is_store), .is_halt(is_halt), .br_kind(br_kind)
    );

    assign op_b = use_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_out = rs1_data - op_b;
            ALU_AND:    alu_out = rs1_data & op_b;
            ALU_OR:     alu_out = rs1_data | op_b;
            ALU_XOR:    alu_out = rs1_data ^ op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = rs1_data + op_b;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_BEQ:  taken = (rs1_data == rs2_data);
            BR_BNE:  taken = (rs1_data != rs2_data);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // ebreak redirects too, flushing the word fetched behind it
    assign redirect    = if_valid & (taken | is_halt);
    assign redirect_pc = if_pc + imm;
    assign halt_seen   = if_valid & is_halt;

    assign data_req   = if_valid & (is_load | is_store);
    assign data_we    = is_store;
    assign data_addr  = rs1_data + imm;
    assign data_wdata = rs2_data;
    assign data_be    = '1;  // word access only

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_valid   <= 1'b0;
            m_is_load <= 1'b0;
        end else begin
            m_valid   <= if_valid & reg_write & (rd != '0);
            m_is_load <= if_valid & is_load;
        end
    end

    always_ff @(posedge clock) begin
        m_rd     <= rd;
        m_result <= (br_kind == BR_JAL) ? if_pc + 32'd4 : alu_out;  // link value
    end

endmodule

//--- source/reg_file_bypass.sv
module reg_file_bypass (
    input  logic                     clock,
    input  logic                     rst_n,
    input  core_types_pkg::reg_idx_t rs1,
    input  core_types_pkg::reg_idx_t rs2,
    output core_types_pkg::data_t    rs1_data,
    output core_types_pkg::data_t    rs2_data,
    input  logic                     wr_en,
    input  core_types_pkg::reg_idx_t wr_idx,
    input  core_types_pkg::data_t    wr_data
);
    import core_types_pkg::*;

    data_t regs [1:31];  // x0 not stored

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // same-cycle write wins, so the memory stage result reaches execute
    assign rs1_data = (rs1 == '0)               ? '0      :
                      (wr_en && wr_idx == rs1)  ? wr_data :
                                                  regs[rs1];
    assign rs2_data = (rs2 == '0)               ? '0      :
                      (wr_en && wr_idx == rs2)  ? wr_data :
                                                  regs[rs2];

endmodule

//--- source/inst_fetch.sv
`include "core_settings.svh"

module inst_fetch (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  run,
    input  logic                  halted,
    input  logic                  fetch_gnt,
    input  logic                  redirect,
    input  core_types_pkg::addr_t redirect_pc,
    output logic                  fetch_req,
    output core_types_pkg::addr_t fetch_addr,
    output logic                  if_valid,
    output core_types_pkg::addr_t if_pc
);
    import core_types_pkg::*;

    addr_t pc;

    assign fetch_req  = run & ~halted;
    assign fetch_addr = pc;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RESET_PC;
            if_pc    <= `RESET_PC;
            if_valid <= 1'b0;
        end else begin
            if_valid <= fetch_gnt & ~redirect;  // drop the shadow word
            if (redirect) begin
                pc <= redirect_pc;
            end else if (fetch_gnt) begin
                pc    <= pc + 32'd4;
                if_pc <= pc;  // address of the word now in flight
            end
        end
    end

endmodule

//--- source/inst_decode.sv
module inst_decode (
    input  core_types_pkg::data_t    inst,
    output core_types_pkg::reg_idx_t rs1, rs2, rd,
    output core_types_pkg::data_t    imm,
    output core_types_pkg::alu_op_e  alu_op,
    output logic                     use_imm, reg_write, is_load, is_store, is_halt,
    output core_types_pkg::br_kind_e br_kind
);
    import core_types_pkg::*;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;
    localparam data_t      EBREAK    = 32'h0010_0073;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_halt   = 1'b0;
        br_kind   = BR_NONE;
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_write = 1'b0;  // shifts, slt not supported
                endcase
            end
            OP_IMM: begin
                imm       = {{20{inst[31]}}, inst[31:20]};
                use_imm   = 1'b1;
                reg_write = (funct3 == 3'b000);  // addi only
            end
            OP_LUI: begin
                imm       = {inst[31:12], 12'b0};
                alu_op    = ALU_PASS_B;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LOAD: begin
                imm       = {{20{inst[31]}}, inst[31:20]};
                is_load   = (funct3 == 3'b010);  // lw only
                reg_write = (funct3 == 3'b010);
            end
            OP_STORE: begin
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                is_store = (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                case (funct3)
                    3'b000:  br_kind = BR_BEQ;
                    3'b001:  br_kind = BR_BNE;
                    default: br_kind = BR_NONE;
                endcase
            end
            OP_JAL: begin
                imm       = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                reg_write = 1'b1;
                br_kind   = BR_JAL;
            end
            OP_SYSTEM: is_halt = (inst == EBREAK);
            default: ;  // unknown opcode is a no-op
        endcase
    end

endmodule

//--- source/mem_bus_pkg.sv
`include "core_settings.svh"

package mem_bus_pkg;

    typedef logic [`DATA_WIDTH/8-1:0]      byte_en_t;
    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_idx_t;

    typedef enum logic [1:0] {
        REQ_LOADER,
        REQ_DATA,
        REQ_FETCH,
        REQ_NONE
    } requester_e;

endpackage

//--- source/core_types_pkg.sv
`include "core_settings.svh"

package core_types_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`REG_WIDTH-1:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_kind_e;

endpackage

//--- source/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define REG_WIDTH  5

`define MEM_WORDS  1024
`define RESET_PC   32'h0000_0000

`endif
